//--- fx2_inbound.f
source/fx2_pkg.sv
source/fx2_rx_if.sv
source/endpoint_scheduler.sv
source/packet_header_capture.sv
source/packet_byte_counter.sv
source/ep2_fifo_writer.sv
source/fx2_inbound.sv
sim/fx2_host_model.sv
sim/tb_fx2_inbound.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the FX2 receive path testbench with Verilator and runs it.
# The run counts as passed only when the pass message shows up in its output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_fx2_inbound \
    --Mdir obj_dir -o tb_fx2_inbound \
    -f fx2_inbound.f \
    || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/tb_fx2_inbound 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "all tests passed" \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

//--- sim/fx2_host_model.sv
//------------------------------
// FX2 host model
// Plays the FX2 OUT FIFOs for EP2 and EP4
// and the command decoder's read level
//------------------------------
`timescale 1ns/1ps

module fx2_host_model (
    input  logic       usb_ifclk,
    input  logic       reset,
    input  logic       run,
    input  logic       usb_slrd,
    input  logic [1:0] usb_addr,
    input  logic       cmd_in_ready,
    output logic [7:0] usb_data_out,
    output logic       usb_ep2_empty,
    output logic       usb_ep4_empty,
    output logic       cmd_in_read,
    output logic       drained,
    output logic       bad_read
);
    // Bytes still waiting in each OUT FIFO
    logic [7:0] ep2_q [$];
    logic [7:0] ep4_q [$];

    // Read strobe seen just before the coming rising edge, and its endpoint
    logic       take_pending;
    logic       take_ep4;

    // Loads one byte into the FIFO of EP4 or of EP2
    task automatic push_byte(input logic to_ep4, input logic [7:0] value);
        if (to_ep4) begin
            ep4_q.push_back(value);
        end else begin
            ep2_q.push_back(value);
        end
    endtask

    initial begin
        usb_data_out  = 8'h00;
        usb_ep2_empty = 1'b1;
        usb_ep4_empty = 1'b1;
        cmd_in_read   = 1'b0;
        drained       = 1'b1;
        bad_read      = 1'b0;
        take_pending  = 1'b0;
        take_ep4      = 1'b0;
        void'($urandom(98051));
        forever begin
            @(negedge usb_ifclk);
            // The byte taken at the last rising edge leaves its FIFO now
            if (take_pending) begin
                if (take_ep4) begin
                    if (ep4_q.size() == 0) begin
                        bad_read = 1'b1;
                    end else begin
                        void'(ep4_q.pop_front());
                    end
                end else begin
                    if (ep2_q.size() == 0) begin
                        bad_read = 1'b1;
                    end else begin
                        void'(ep2_q.pop_front());
                    end
                end
            end
            drained = (ep2_q.size() == 0) && (ep4_q.size() == 0);
            // An FX2 FIFO may also look empty for a while even though it holds data
            usb_ep2_empty = !run || (ep2_q.size() == 0) || ($urandom_range(3, 0) == 0);
            usb_ep4_empty = !run || (ep4_q.size() == 0) || ($urandom_range(3, 0) == 0);
            if (usb_addr[0]) begin
                usb_data_out = (ep4_q.size() != 0) ? ep4_q[0] : 8'h00;
            end else begin
                usb_data_out = (ep2_q.size() != 0) ? ep2_q[0] : 8'h00;
            end
            // The decoder stalls now and then while a command is open
            cmd_in_read = run && cmd_in_ready && ($urandom_range(2, 0) != 0);
            // Let the DUT's strobe settle on the new inputs before noting it
            #1;
            take_pending = !reset && !usb_slrd;
            take_ep4     = usb_addr[0];
            // A real FX2 hands out stale data when strobed while it shows empty
            if (take_pending && (take_ep4 ? usb_ep4_empty : usb_ep2_empty)) begin
                bad_read = 1'b1;
            end
        end
    end

endmodule

//--- sim/fx2_stimulus.txt
// Columns: endpoint (2 or 4), then one FX2 byte in hex, in FIFO order per endpoint
// Frames are ff, id, length high, length low, data; other bytes before ff are junk
2 12
2 34
2 ff
2 05
2 00
2 03
2 a0
2 ff
2 a2
2 ff
2 06
2 00
2 00
2 ff
2 03
2 00
2 02
2 b0
2 b1
4 55
4 ff
4 10
4 00
4 02
4 c1
4 c2
4 ff
4 20
4 00
4 00
4 ff
4 21
4 00
4 01
4 d0

//--- sim/tb_fx2_inbound.sv
//------------------------------
// Testbench for the FX2 receive path
// Feeds framed EP2 and EP4 traffic from the
// stimulus file and checks the outputs
//------------------------------
`timescale 1ns/1ps

module tb_fx2_inbound;
    import fx2_pkg::*;

    logic                     usb_ifclk;
    logic                     reset;
    logic [7:0]               usb_data_out;
    logic                     usb_ep2_empty;
    logic                     usb_ep4_empty;
    logic                     cmd_in_read;
    logic                     usb_slrd;
    logic [1:0]               usb_addr;
    logic [7:0]               ep2_port_data;
    logic [NUM_EP2_PORTS-1:0] ep2_port_write;
    logic [7:0]               cmd_in_id;
    logic [15:0]              cmd_in_length;
    logic [7:0]               cmd_in_data;
    logic                     cmd_in_ready;
    logic                     run;
    logic                     drained;
    logic                     bad_read;
    logic                     monitor_on;

    // Expected EP2 writes and EP4 command frames, in arrival order
    logic [1:0]  exp_port [$];
    logic [7:0]  exp_ep2_byte [$];
    logic [7:0]  exp_cmd_id [$];
    logic [15:0] exp_cmd_len [$];
    logic [7:0]  exp_cmd_byte [$];

    // Framing parser state for each endpoint where index 0 is EP2 and index 1 is EP4
    int          pstate [2];
    logic [7:0]  pid [2];
    logic [15:0] plen [2];
    int          pleft [2];

    int          ep2_total;
    int          cmd_total;
    int          writes_seen;
    int          cmd_seen;
    int          cmd_left;
    logic [7:0]  cur_id;
    logic [15:0] cur_len;
    logic        ready_prev;

    fx2_inbound u_dut (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .usb_data_out   (usb_data_out),
        .usb_ep2_empty  (usb_ep2_empty),
        .usb_ep4_empty  (usb_ep4_empty),
        .cmd_in_read    (cmd_in_read),
        .usb_slrd       (usb_slrd),
        .usb_addr       (usb_addr),
        .ep2_port_data  (ep2_port_data),
        .ep2_port_write (ep2_port_write),
        .cmd_in_id      (cmd_in_id),
        .cmd_in_length  (cmd_in_length),
        .cmd_in_data    (cmd_in_data),
        .cmd_in_ready   (cmd_in_ready)
    );

    fx2_host_model u_host (
        .usb_ifclk     (usb_ifclk),
        .reset         (reset),
        .run           (run),
        .usb_slrd      (usb_slrd),
        .usb_addr      (usb_addr),
        .cmd_in_ready  (cmd_in_ready),
        .usb_data_out  (usb_data_out),
        .usb_ep2_empty (usb_ep2_empty),
        .usb_ep4_empty (usb_ep4_empty),
        .cmd_in_read   (cmd_in_read),
        .drained       (drained),
        .bad_read      (bad_read)
    );

    initial begin
        usb_ifclk = 1'b0;
        forever #20 usb_ifclk = ~usb_ifclk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // Applies the framing rule to one stimulus byte and records what the DUT must produce
    task automatic frame_byte(input int e, input logic [7:0] b);
        case (pstate[e])
            0: begin
                // Anything other than the header byte is junk and is dropped
                if (b == 8'hFF) begin
                    pstate[e] = 1;
                end
            end
            1: begin
                pid[e]    = b;
                pstate[e] = 2;
            end
            2: begin
                plen[e][15:8] = b;
                pstate[e]     = 3;
            end
            3: begin
                plen[e][7:0] = b;
                pleft[e]     = int'(plen[e]);
                pstate[e]    = (plen[e] == 0) ? 0 : 4;
                // A zero-length command never raises cmd_in_ready
                if ((e == 1) && (plen[e] != 0)) begin
                    exp_cmd_id.push_back(pid[e]);
                    exp_cmd_len.push_back(plen[e]);
                end
            end
            default: begin
                if (e == 0) begin
                    exp_port.push_back(pid[0][1:0]);
                    exp_ep2_byte.push_back(b);
                end else begin
                    exp_cmd_byte.push_back(b);
                end
                pleft[e] = pleft[e] - 1;
                if (pleft[e] == 0) begin
                    pstate[e] = 0;
                end
            end
        endcase
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    ep;
        int    value;
        string line;
        fd = $fopen("sim/fx2_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file sim/fx2_stimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                // Comment and blank lines do not scan as two fields
                if ((n > 0) && ($sscanf(line, "%d %h", ep, value) == 2)) begin
                    if ((ep != 2) && (ep != 4)) begin
                        abort_run($sformatf("stimulus names an unknown endpoint %0d", ep));
                    end else begin
                        u_host.push_byte(ep == 4, value[7:0]);
                        frame_byte((ep == 4) ? 1 : 0, value[7:0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Checks one cycle of DUT outputs against the expected queues
    task automatic check_outputs();
        logic [1:0] port;
        logic [7:0] value;
        if (bad_read) begin
            abort_run("usb_slrd strobed an endpoint that showed empty or had no bytes left");
        end
        // Only the EP2 and EP4 addresses are ever driven
        compare_value("usb_addr[1]", 32'(usb_addr[1]), 32'd0);
        if (ep2_port_write != '0) begin
            if (exp_port.size() == 0) begin
                abort_run("EP2 write seen when no more data bytes were expected");
            end else begin
                port  = exp_port.pop_front();
                value = exp_ep2_byte.pop_front();
                compare_value("ep2_port_write", 32'(ep2_port_write), 32'(1) << port);
                compare_value("ep2_port_data", 32'(ep2_port_data), 32'(value));
                writes_seen++;
            end
        end
        if (cmd_in_ready && !ready_prev) begin
            if (exp_cmd_id.size() == 0) begin
                abort_run("cmd_in_ready rose when no command frame was expected");
            end else begin
                cur_id   = exp_cmd_id.pop_front();
                cur_len  = exp_cmd_len.pop_front();
                cmd_left = int'(cur_len);
            end
        end
        if (cmd_in_ready) begin
            compare_value("cmd_in_id", 32'(cmd_in_id), 32'(cur_id));
            compare_value("cmd_in_length", 32'(cmd_in_length), 32'(cur_len));
            if (cmd_left == 0) begin
                abort_run("cmd_in_ready stayed high after the last command byte");
            end
            // A byte moves to the decoder only when it reads and the FX2 is strobed
            if (!usb_slrd) begin
                compare_value("usb_addr", 32'(usb_addr), 32'd1);
                compare_value("cmd_in_read", 32'(cmd_in_read), 32'd1);
                value = exp_cmd_byte.pop_front();
                compare_value("cmd_in_data", 32'(cmd_in_data), 32'(value));
                cmd_left--;
                cmd_seen++;
            end
        end else if (ready_prev && (cmd_left != 0)) begin
            abort_run($sformatf("cmd_in_ready fell with %0d command bytes missing", cmd_left));
        end
        ready_prev = cmd_in_ready;
    endtask

    // Outputs are sampled mid-cycle, well after the falling-edge drive has settled
    initial begin
        forever begin
            @(negedge usb_ifclk);
            #5;
            if (monitor_on) begin
                check_outputs();
            end
        end
    end

    initial begin
        int cycles;
        reset       = 1'b1;
        run         = 1'b0;
        monitor_on  = 1'b0;
        ready_prev  = 1'b0;
        writes_seen = 0;
        cmd_seen    = 0;
        cmd_left    = 0;
        cur_id      = 8'h00;
        cur_len     = 16'h0000;
        for (int e = 0; e < 2; e++) begin
            pstate[e] = 0;
            pleft[e]  = 0;
        end
        load_stimulus();
        ep2_total = exp_port.size();
        cmd_total = exp_cmd_byte.size();

        repeat (16) @(negedge usb_ifclk);
        reset      = 1'b0;
        monitor_on = 1'b1;

        // Idle after reset with both FIFOs held empty
        for (int i = 0; i < 8; i++) begin
            @(negedge usb_ifclk);
            #5;
            compare_value("usb_slrd", 32'(usb_slrd), 32'd1);
            compare_value("ep2_port_write", 32'(ep2_port_write), 32'd0);
            compare_value("cmd_in_ready", 32'(cmd_in_ready), 32'd0);
            compare_value("cmd_in_id", 32'(cmd_in_id), 32'h38);
        end
        run = 1'b1;

        cycles = 0;
        while (!(drained && (exp_port.size() == 0) && (exp_cmd_byte.size() == 0)
                 && !cmd_in_ready)) begin
            if (cycles >= 4000) begin
                abort_run("timed out waiting for all frames to arrive");
            end
            @(negedge usb_ifclk);
            #10;
            cycles++;
        end
        // A few quiet cycles so any stray write or command byte is caught
        repeat (6) @(negedge usb_ifclk);
        #10;

        if ((writes_seen == ep2_total) && (cmd_seen == cmd_total) && drained) begin
            $display("all tests passed");
            $finish;
        end else begin
            abort_run($sformatf("count mismatch: %0d of %0d EP2 writes, %0d of %0d command bytes",
                                writes_seen, ep2_total, cmd_seen, cmd_total));
        end
    end

endmodule

//--- source/endpoint_scheduler.sv
//------------------------------
// Endpoint scheduler
// Alternates between EP2 and EP4, tracks the
// frame state of each and drives the FX2 read
// strobe and address
//------------------------------
`timescale 1ns/1ps

module endpoint_scheduler (
    input  logic                usb_ifclk,
    input  logic                reset,
    input  logic                usb_ep2_empty,
    input  logic                usb_ep4_empty,
    input  fx2_pkg::usb_byte_t  usb_data_out,
    input  logic                cmd_in_read,
    input  logic                ep2_last_byte,
    input  logic                ep4_last_byte,
    input  logic                ep2_len_zero,
    input  logic                ep4_len_zero,
    output logic                usb_slrd,
    output logic [1:0]          usb_addr,
    output logic                cmd_in_ready,
    fx2_rx_if.sched             rx
);
    import fx2_pkg::*;

    // Endpoint being serviced and the frame state kept for each endpoint
    ep_sel_t       ep_sel;
    packet_state_t pkt_state [2];

    packet_state_t cur_state;
    packet_state_t next_state;
    ep_sel_t       next_sel;
    ep_sel_t       other_ep;
    logic          sel_empty;
    logic          cmd_hold;
    logic          byte_taken;
    logic          sel_last_byte;
    logic          sel_len_zero;

    // Everything below is seen through the selected endpoint
    assign cur_state     = pkt_state[ep_sel];
    assign other_ep      = (ep_sel == EP_SEL_EP2) ? EP_SEL_EP4 : EP_SEL_EP2;
    assign sel_empty     = (ep_sel == EP_SEL_EP2) ? usb_ep2_empty : usb_ep4_empty;
    assign sel_last_byte = (ep_sel == EP_SEL_EP2) ? ep2_last_byte : ep4_last_byte;
    assign sel_len_zero  = (ep_sel == EP_SEL_EP2) ? ep2_len_zero : ep4_len_zero;

    // The command decoder paces EP4 data with its read level
    assign cmd_hold = (ep_sel == EP_SEL_EP4) && (cur_state == PKT_DATA) && !cmd_in_read;

    // Read whenever there is a byte and somewhere to put it
    assign byte_taken = !sel_empty && (cur_state != PKT_DONE) && !cmd_hold;
    assign usb_slrd   = !byte_taken;
    assign usb_addr   = {1'b0, ep_sel};

    // EP4 holds the selection for the whole data phase, so its own state is enough
    assign cmd_in_ready = (pkt_state[EP_SEL_EP4] == PKT_DATA);

    assign rx.ep_sel     = ep_sel;
    assign rx.state      = cur_state;
    assign rx.byte_taken = byte_taken;
    assign rx.rx_byte    = usb_data_out;

    always_comb begin
        next_state = cur_state;
        next_sel   = ep_sel;
        case (cur_state)
            PKT_WAITING: begin
                // Junk bytes and an empty endpoint both end this visit
                if (byte_taken && (usb_data_out == HEADER_BYTE)) begin
                    next_state = PKT_HDR_ID;
                end else begin
                    next_state = PKT_DONE;
                end
            end
            // Header reads give way to the other endpoint when this one runs dry
            PKT_HDR_ID: begin
                if (byte_taken) begin
                    next_state = PKT_HDR_LEN_HI;
                end else begin
                    next_sel = other_ep;
                end
            end
            PKT_HDR_LEN_HI: begin
                if (byte_taken) begin
                    next_state = PKT_HDR_LEN_LO;
                end else begin
                    next_sel = other_ep;
                end
            end
            PKT_HDR_LEN_LO: begin
                // An empty frame has no data phase at all
                if (byte_taken) begin
                    next_state = sel_len_zero ? PKT_DONE : PKT_DATA;
                end else begin
                    next_sel = other_ep;
                end
            end
            PKT_DATA: begin
                // No endpoint switch here, the frame is finished first
                if (byte_taken && sel_last_byte) begin
                    next_state = PKT_DONE;
                end
            end
            PKT_DONE: begin
                next_state = PKT_WAITING;
                next_sel   = other_ep;
            end
            default: begin
                next_state = PKT_WAITING;
            end
        endcase
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            ep_sel                <= EP_SEL_EP2;
            pkt_state[EP_SEL_EP2] <= PKT_WAITING;
            pkt_state[EP_SEL_EP4] <= PKT_WAITING;
        end else begin
            // Only the selected endpoint advances; the other keeps its progress
            pkt_state[ep_sel] <= next_state;
            ep_sel            <= next_sel;
        end
    end

    // The FX2 must never be strobed on the endpoint that its address selects while empty
    a_no_read_when_empty : assert property (@(posedge usb_ifclk) disable iff (reset)
        !usb_slrd |-> !((usb_addr == 2'b00) ? usb_ep2_empty : usb_ep4_empty));

endmodule

//--- source/ep2_fifo_writer.sv
//------------------------------
// EP2 tracking-FIFO writer
// Registers each EP2 data byte with a
// one-hot write to the frame's port
//------------------------------
`timescale 1ns/1ps

module ep2_fifo_writer (
    input  logic                                usb_ifclk,
    input  logic                                reset,
    fx2_rx_if.sink                              rx,
    input  fx2_pkg::ep2_port_t                  port_index,
    output fx2_pkg::usb_byte_t                  ep2_port_data,
    output logic [fx2_pkg::NUM_EP2_PORTS-1:0]   ep2_port_write
);
    import fx2_pkg::*;

    // An EP2 data byte is consumed at this edge
    logic take;

    assign take = (rx.ep_sel == EP_SEL_EP2) && (rx.state == PKT_DATA) && rx.byte_taken;

    // The byte that goes out with each write pulse
    always_ff @(posedge usb_ifclk) begin
        if (take) begin
            ep2_port_data <= rx.rx_byte;
        end
    end

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            ep2_port_write <= '0;
        end else begin
            // One pulse per byte, on the port named by the frame id
            for (int p = 0; p < NUM_EP2_PORTS; p++) begin
                ep2_port_write[p] <= take && (port_index == ep2_port_t'(p));
            end
        end
    end

    a_write_onehot : assert property (@(posedge usb_ifclk) disable iff (reset)
        $onehot0(ep2_port_write));

endmodule

//--- source/fx2_inbound.sv
//------------------------------
// FX2 slave-FIFO receive path
// Reads framed EP2 sample data into the
// tracking FIFOs and EP4 commands into the
// command decoder
//------------------------------
`timescale 1ns/1ps

module fx2_inbound (
    input  logic                                usb_ifclk,
    input  logic                                reset,
    input  fx2_pkg::usb_byte_t                  usb_data_out,
    input  logic                                usb_ep2_empty,
    input  logic                                usb_ep4_empty,
    input  logic                                cmd_in_read,
    output logic                                usb_slrd,
    output logic [1:0]                          usb_addr,
    output fx2_pkg::usb_byte_t                  ep2_port_data,
    output logic [fx2_pkg::NUM_EP2_PORTS-1:0]   ep2_port_write,
    output fx2_pkg::cmd_id_t                    cmd_in_id,
    output fx2_pkg::pkt_len_t                   cmd_in_length,
    output fx2_pkg::usb_byte_t                  cmd_in_data,
    output logic                                cmd_in_ready
);
    import fx2_pkg::*;

    // Per-endpoint header fields and data-phase flags
    ep2_port_t ep2_port_index;
    pkt_len_t  ep2_length;
    logic      ep2_len_zero;
    logic      ep4_len_zero;
    logic      ep2_last_byte;
    logic      ep4_last_byte;

    fx2_rx_if rx_bus ();

    endpoint_scheduler u_scheduler (
        .usb_ifclk     (usb_ifclk),
        .reset         (reset),
        .usb_ep2_empty (usb_ep2_empty),
        .usb_ep4_empty (usb_ep4_empty),
        .usb_data_out  (usb_data_out),
        .cmd_in_read   (cmd_in_read),
        .ep2_last_byte (ep2_last_byte),
        .ep4_last_byte (ep4_last_byte),
        .ep2_len_zero  (ep2_len_zero),
        .ep4_len_zero  (ep4_len_zero),
        .usb_slrd      (usb_slrd),
        .usb_addr      (usb_addr),
        .cmd_in_ready  (cmd_in_ready),
        .rx            (rx_bus.sched)
    );

    // EP2 id picks the tracking-FIFO port
    packet_header_capture #(
        .OWN_EP   (EP_SEL_EP2),
        .id_t     (ep2_port_t),
        .ID_RESET (ep2_port_t'(0))
    ) u_ep2_header (
        .usb_ifclk (usb_ifclk),
        .reset     (reset),
        .rx        (rx_bus.sink),
        .id        (ep2_port_index),
        .length    (ep2_length),
        .len_zero  (ep2_len_zero)
    );

    // EP4 header goes straight to the command decoder
    packet_header_capture #(
        .OWN_EP   (EP_SEL_EP4),
        .id_t     (cmd_id_t),
        .ID_RESET (COMMAND_NOP)
    ) u_ep4_header (
        .usb_ifclk (usb_ifclk),
        .reset     (reset),
        .rx        (rx_bus.sink),
        .id        (cmd_in_id),
        .length    (cmd_in_length),
        .len_zero  (ep4_len_zero)
    );

    packet_byte_counter #(
        .OWN_EP (EP_SEL_EP2)
    ) u_ep2_counter (
        .usb_ifclk (usb_ifclk),
        .reset     (reset),
        .rx        (rx_bus.sink),
        .length    (ep2_length),
        .last_byte (ep2_last_byte)
    );

    packet_byte_counter #(
        .OWN_EP (EP_SEL_EP4)
    ) u_ep4_counter (
        .usb_ifclk (usb_ifclk),
        .reset     (reset),
        .rx        (rx_bus.sink),
        .length    (cmd_in_length),
        .last_byte (ep4_last_byte)
    );

    ep2_fifo_writer u_ep2_writer (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .rx             (rx_bus.sink),
        .port_index     (ep2_port_index),
        .ep2_port_data  (ep2_port_data),
        .ep2_port_write (ep2_port_write)
    );

    // The decoder samples FX2 data in the same cycle as its read level
    assign cmd_in_data = usb_data_out;

endmodule

//--- source/fx2_pkg.sv
//------------------------------
// FX2 receive path definitions
// Endpoint codes, packet states, frame
// constants and the payload types shared
// by the slave-FIFO receive logic
//------------------------------

package fx2_pkg;

    // Only the two OUT endpoints remain, so one bit selects between them
    // and the FX2 sees address 00 for EP2 and 01 for EP4
    typedef enum logic {
        EP_SEL_EP2 = 1'b0,
        EP_SEL_EP4 = 1'b1
    } ep_sel_t;

    // Progress through one frame on one endpoint
    typedef enum logic [2:0] {
        PKT_WAITING    = 3'd0,
        PKT_HDR_ID     = 3'd1,
        PKT_HDR_LEN_HI = 3'd2,
        PKT_HDR_LEN_LO = 3'd3,
        PKT_DATA       = 3'd4,
        PKT_DONE       = 3'd5
    } packet_state_t;

    // Number of tracking-FIFO write ports fed from EP2
    localparam int NUM_EP2_PORTS = 4;

    // Every frame opens with this byte
    localparam logic [7:0] HEADER_BYTE = 8'hFF;

    // Command id presented to the decoder until a real command arrives
    localparam logic [7:0] COMMAND_NOP = 8'h38;

    // One byte as moved across the FX2 slave FIFO bus
    typedef logic [7:0] usb_byte_t;

    // Frame length taken from the two length bytes of the header
    typedef logic [15:0] pkt_len_t;

    // Index of an EP2 tracking-FIFO write port
    typedef logic [$clog2(NUM_EP2_PORTS)-1:0] ep2_port_t;

    // Command id carried in the id byte of an EP4 frame
    typedef logic [7:0] cmd_id_t;

endpackage

//--- source/fx2_rx_if.sv
//------------------------------
// Per-byte receive bus
// Carries the selected endpoint, its frame
// state and the byte being taken from the FX2
//------------------------------
`timescale 1ns/1ps

interface fx2_rx_if;
    import fx2_pkg::*;

    // Endpoint currently addressed on the FX2
    ep_sel_t       ep_sel;

    // Frame state of the addressed endpoint only
    packet_state_t state;

    // High when usb_slrd is low, so the byte is consumed at the coming edge
    logic          byte_taken;

    // FX2 output data, valid whenever byte_taken is high
    usb_byte_t     rx_byte;

    // The scheduler owns the whole bus
    modport sched (
        output ep_sel,
        output state,
        output byte_taken,
        output rx_byte
    );

    // Header capture, byte counters and the EP2 writer only listen
    modport sink (
        input ep_sel,
        input state,
        input byte_taken,
        input rx_byte
    );

endinterface

//--- source/packet_byte_counter.sv
//------------------------------
// Data byte counter
// Counts the data bytes of a frame on one
// endpoint and flags the final byte
//------------------------------
`timescale 1ns/1ps

module packet_byte_counter #(
    parameter fx2_pkg::ep_sel_t OWN_EP = fx2_pkg::EP_SEL_EP2
) (
    input  logic              usb_ifclk,
    input  logic              reset,
    fx2_rx_if.sink            rx,
    input  fx2_pkg::pkt_len_t length,
    output logic              last_byte
);
    import fx2_pkg::*;

    // Bytes of the current frame already taken
    pkt_len_t count;
    logic     own;

    assign own = (rx.ep_sel == OWN_EP);

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            count <= '0;
        end else if (own && rx.byte_taken) begin
            // A fresh frame starts as its lower length byte is taken
            if (rx.state == PKT_HDR_LEN_LO) begin
                count <= '0;
            end else if (rx.state == PKT_DATA) begin
                count <= count + pkt_len_t'(1);
            end
        end
    end

    // The byte on the bus right now is the last one of the frame
    assign last_byte = ((count + pkt_len_t'(1)) == length);

    // The scheduler must leave the data phase before the count reaches the length
    a_count_in_range : assert property (@(posedge usb_ifclk) disable iff (reset)
        (own && (rx.state == PKT_DATA)) |-> (count < length));

endmodule

//--- source/packet_header_capture.sv
//------------------------------
// Frame header capture
// Holds the id and length of frames on one
// endpoint, loaded byte by byte from the bus
//------------------------------
`timescale 1ns/1ps

module packet_header_capture #(
    parameter fx2_pkg::ep_sel_t OWN_EP = fx2_pkg::EP_SEL_EP2,
    parameter type id_t = fx2_pkg::ep2_port_t,
    parameter id_t ID_RESET = id_t'(0)
) (
    input  logic              usb_ifclk,
    input  logic              reset,
    fx2_rx_if.sink            rx,
    output id_t               id,
    output fx2_pkg::pkt_len_t length,
    output logic              len_zero
);
    import fx2_pkg::*;

    // A header byte belongs here only when our endpoint is the one addressed
    logic take;

    assign take = (rx.ep_sel == OWN_EP) && rx.byte_taken;

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            id     <= ID_RESET;
            length <= '0;
        end else if (take) begin
            case (rx.state)
                // The id keeps only the low bits that the id type can hold
                PKT_HDR_ID: begin
                    id <= id_t'(rx.rx_byte);
                end
                PKT_HDR_LEN_HI: begin
                    length[15:8] <= rx.rx_byte;
                end
                PKT_HDR_LEN_LO: begin
                    length[7:0] <= rx.rx_byte;
                end
                default: begin
                    // Data and idle states leave the header alone
                    id <= id;
                end
            endcase
        end
    end

    // Looks ahead at the lower length byte on the bus so the scheduler can
    // skip the data phase in the same cycle that this byte is taken
    assign len_zero = (length[15:8] == 8'h00) && (rx.rx_byte == 8'h00);

endmodule
